//--- logic/isa_pkg.sv
// mips32 instruction encodings and architectural constants
// instruction word union with r, i and j views
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // first fetch after reset
    localparam logic [xlen-1:0] reset_pc = 32'hbfc0_0000;

    // major opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // special function codes
    localparam logic [5:0] funct_addu = 6'b100001;
    localparam logic [5:0] funct_subu = 6'b100011;
    localparam logic [5:0] funct_and  = 6'b100100;
    localparam logic [5:0] funct_or   = 6'b100101;
    localparam logic [5:0] funct_slt  = 6'b101010;

    // one word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [4:0]            shamt;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [5:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [15:0]           imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_u;

endpackage

//--- logic/core_pkg.sv
// pipeline-internal widths
// alu operation codes
package core_pkg;

    localparam int alu_op_w = 3;

    localparam logic [alu_op_w-1:0] alu_add = 3'd0;
    localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
    localparam logic [alu_op_w-1:0] alu_and = 3'd2;
    localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
    localparam logic [alu_op_w-1:0] alu_slt = 3'd4;
    // upper immediate, b shifted into the high half
    localparam logic [alu_op_w-1:0] alu_lui = 3'd5;

endpackage

//--- logic/reg_file.sv
// 32 x 32 register file, two read ports and one write port
// same-cycle write passes to the reads, r0 is zero
module reg_file import isa_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    input  logic                  wen,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata
);

    logic [xlen-1:0] regs [32];

    function automatic logic [xlen-1:0] rd_port(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wen && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    assign rdata1 = rd_port(raddr1);
    assign rdata2 = rd_port(raddr2);

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

//--- logic/fetch_stage.sv
// fetch stage
// pc of the decode instruction, next fetch address, pending branch
module fetch_stage import isa_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            allowin,
    input  logic            branch_taken,
    input  logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] inst_sram_addr,
    output logic            fd_valid,
    output logic [xlen-1:0] fd_pc
);

    logic            br_pending;
    logic [xlen-1:0] br_target_q;
    logic [xlen-1:0] seq_pc;

    assign seq_pc = fd_pc + 32'd4;

    // a branch in decode lets its delay slot go out first,
    // the target is presented one cycle later
    always_comb begin
        if (!resetn) begin
            inst_sram_addr = reset_pc;
        end else if (!allowin) begin
            // refetch the stalled word
            inst_sram_addr = fd_pc;
        end else if (br_pending) begin
            inst_sram_addr = br_target_q;
        end else begin
            inst_sram_addr = seq_pc;
        end
    end

    // fd_pc starts one word early so the first sequential address is reset_pc
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd_valid   <= 1'b0;
            fd_pc      <= reset_pc - 32'd4;
            br_pending <= 1'b0;
        end else if (allowin) begin
            fd_valid   <= 1'b1;
            fd_pc      <= inst_sram_addr;
            br_pending <= branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (allowin) begin
            br_target_q <= branch_target;
        end
    end

endmodule

//--- logic/decode_stage.sv
// decode stage
// field decode, operand forwarding, load-use and branch interlock,
// branch resolution and the decode to execute register
module decode_stage import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  fd_valid,
    input  logic [xlen-1:0]       fd_pc,
    input  logic [xlen-1:0]       inst_sram_rdata,
    output logic [reg_addr_w-1:0] rf_raddr1,
    output logic [reg_addr_w-1:0] rf_raddr2,
    input  logic [xlen-1:0]       rf_rdata1,
    input  logic [xlen-1:0]       rf_rdata2,
    input  logic [xlen-1:0]       ex_result,
    input  logic [reg_addr_w-1:0] ex_dest,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic                  mem_valid,
    input  logic [xlen-1:0]       mem_result,
    input  logic [reg_addr_w-1:0] mem_dest,
    input  logic                  mem_reg_write,
    input  logic                  wb_valid,
    input  logic [xlen-1:0]       wb_data,
    input  logic [reg_addr_w-1:0] wb_dest,
    input  logic                  wb_reg_write,
    output logic                  allowin,
    output logic                  branch_taken,
    output logic [xlen-1:0]       branch_target,
    output logic                  de_valid,
    output logic [xlen-1:0]       de_pc,
    output logic [xlen-1:0]       de_a,
    output logic [xlen-1:0]       de_b,
    output logic [xlen-1:0]       de_store_data,
    output logic [alu_op_w-1:0]   de_alu_op,
    output logic                  de_mem_read,
    output logic                  de_mem_write,
    output logic                  de_reg_write,
    output logic [reg_addr_w-1:0] de_dest
);

    instr_u                inst;
    logic [5:0]            op;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [alu_op_w-1:0]   alu_op;
    logic [xlen-1:0]       imm_ext;
    logic [xlen-1:0]       a_val;
    logic [xlen-1:0]       b_val;
    logic [xlen-1:0]       seq_pc;
    logic [reg_addr_w-1:0] dest;
    logic use_imm, reg_write, mem_read, mem_write, uses_rt;
    logic is_beq, is_bne, is_j, uses_rs;
    logic load_hazard, branch_hazard, stall;

    assign inst      = inst_sram_rdata;
    assign op        = inst.r.opcode;
    assign rs        = inst.i.rs;
    assign rt        = inst.i.rt;
    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;
    // lui and j carry no rs field
    assign uses_rs   = !is_j && (op != op_lui);

    // ------------------------------------------------------------------------
    // control decode
    // ------------------------------------------------------------------------
    always_comb begin
        alu_op    = alu_add;
        imm_ext   = {{16{inst.i.imm[15]}}, inst.i.imm};
        use_imm   = 1'b1;
        reg_write = 1'b0;
        dest      = rt;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        uses_rt   = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (op)
            op_special: begin
                use_imm   = 1'b0;
                uses_rt   = 1'b1;
                dest      = inst.r.rd;
                reg_write = 1'b1;
                case (inst.r.funct)
                    funct_addu: alu_op = alu_add;
                    funct_subu: alu_op = alu_sub;
                    funct_and:  alu_op = alu_and;
                    funct_or:   alu_op = alu_or;
                    funct_slt:  alu_op = alu_slt;
                    // unknown function, no write
                    default:    reg_write = 1'b0;
                endcase
            end
            op_addiu: reg_write = 1'b1;
            op_ori: begin
                alu_op    = alu_or;
                imm_ext   = {16'h0, inst.i.imm};
                reg_write = 1'b1;
            end
            op_lui: begin
                alu_op    = alu_lui;
                imm_ext   = {16'h0, inst.i.imm};
                reg_write = 1'b1;
            end
            op_lw: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            op_sw: begin
                mem_write = 1'b1;
                uses_rt   = 1'b1;
            end
            op_beq: begin
                is_beq  = 1'b1;
                uses_rt = 1'b1;
            end
            op_bne: begin
                is_bne  = 1'b1;
                uses_rt = 1'b1;
            end
            op_j:    is_j = 1'b1;
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // forwarding, youngest producer wins
    // ------------------------------------------------------------------------
    function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] src,
                                            input logic [xlen-1:0] rf_val);
        if (src == '0) begin
            return '0;
        end else if (ex_reg_write && ex_dest == src) begin
            return ex_result;
        end else if (mem_valid && mem_reg_write && mem_dest == src) begin
            return mem_result;
        end else if (wb_valid && wb_reg_write && wb_dest == src) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    assign a_val = fwd(rs, rf_rdata1);
    assign b_val = fwd(rt, rf_rdata2);

    // load data is not ready until memory
    assign load_hazard = ex_reg_write && ex_mem_read && (ex_dest != '0) &&
                         ((uses_rs && rs == ex_dest) || (uses_rt && rt == ex_dest));
    // compare happens here so any execute result is too late
    assign branch_hazard = (is_beq || is_bne) && ex_reg_write && (ex_dest != '0) &&
                           (rs == ex_dest || rt == ex_dest);
    assign stall   = fd_valid && (load_hazard || branch_hazard);
    assign allowin = !stall;

    // branch resolution
    assign seq_pc       = fd_pc + 32'd4;
    assign branch_taken = fd_valid && !stall &&
                          ((is_beq && a_val == b_val) || (is_bne && a_val != b_val) || is_j);
    assign branch_target = is_j ? {seq_pc[31:28], inst.j.target, 2'b00}
                                : seq_pc + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};

    // stalled slot leaves a bubble in execute
    always_ff @(posedge clk) begin
        if (!resetn) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= fd_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        de_pc         <= fd_pc;
        de_a          <= a_val;
        de_b          <= use_imm ? imm_ext : b_val;
        de_store_data <= b_val;
        de_alu_op     <= alu_op;
        de_mem_read   <= mem_read;
        de_mem_write  <= mem_write;
        de_reg_write  <= reg_write;
        de_dest       <= dest;
    end

endmodule

//--- logic/execute_stage.sv
// execute stage
// alu, data sram address and store drive, execute to memory register
module execute_stage import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  de_valid,
    input  logic [xlen-1:0]       de_pc,
    input  logic [xlen-1:0]       de_a,
    input  logic [xlen-1:0]       de_b,
    input  logic [xlen-1:0]       de_store_data,
    input  logic [alu_op_w-1:0]   de_alu_op,
    input  logic                  de_mem_read,
    input  logic                  de_mem_write,
    input  logic                  de_reg_write,
    input  logic [reg_addr_w-1:0] de_dest,
    output logic [3:0]            data_sram_wen,
    output logic [xlen-1:0]       data_sram_addr,
    output logic [xlen-1:0]       data_sram_wdata,
    output logic [xlen-1:0]       ex_result,
    output logic [reg_addr_w-1:0] ex_dest,
    output logic                  ex_reg_write,
    output logic                  ex_mem_read,
    output logic                  em_valid,
    output logic [xlen-1:0]       em_pc,
    output logic [xlen-1:0]       em_result,
    output logic                  em_mem_read,
    output logic                  em_reg_write,
    output logic [reg_addr_w-1:0] em_dest
);

    always_comb begin
        case (de_alu_op)
            alu_add: ex_result = de_a + de_b;
            alu_sub: ex_result = de_a - de_b;
            alu_and: ex_result = de_a & de_b;
            alu_or:  ex_result = de_a | de_b;
            alu_slt: ex_result = {31'h0, $signed(de_a) < $signed(de_b)};
            alu_lui: ex_result = {de_b[15:0], 16'h0};
            default: ex_result = '0;
        endcase
    end

    // lw and sw use the adder result as address
    assign data_sram_addr  = ex_result;
    assign data_sram_wdata = de_store_data;
    assign data_sram_wen   = {4{de_valid && de_mem_write}};

    // forwarding view, qualified by valid
    assign ex_dest      = de_dest;
    assign ex_reg_write = de_valid && de_reg_write;
    assign ex_mem_read  = de_mem_read;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            em_valid <= 1'b0;
        end else begin
            em_valid <= de_valid;
        end
    end

    always_ff @(posedge clk) begin
        em_pc        <= de_pc;
        em_result    <= ex_result;
        em_mem_read  <= de_mem_read;
        em_reg_write <= de_reg_write;
        em_dest      <= de_dest;
    end

endmodule

//--- logic/mem_wb_stage.sv
// memory and writeback
// load data select, writeback register, register file write and debug port
module mem_wb_stage import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  em_valid,
    input  logic [xlen-1:0]       em_pc,
    input  logic [xlen-1:0]       em_result,
    input  logic                  em_mem_read,
    input  logic                  em_reg_write,
    input  logic [reg_addr_w-1:0] em_dest,
    input  logic [xlen-1:0]       data_sram_rdata,
    output logic [xlen-1:0]       mem_result,
    output logic                  wb_valid,
    output logic                  wb_reg_write,
    output logic [reg_addr_w-1:0] wb_dest,
    output logic [xlen-1:0]       wb_data,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic [xlen-1:0] wb_pc;

    // sram word arrives while the load sits here
    assign mem_result = em_mem_read ? data_sram_rdata : em_result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= em_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc        <= em_pc;
        wb_reg_write <= em_reg_write;
        wb_dest      <= em_dest;
        wb_data      <= mem_result;
    end

    // ------------------------------------------------------------------------
    // retire, writes to r0 are dropped
    // ------------------------------------------------------------------------
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_valid && wb_reg_write && (wb_dest != '0)}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

//--- logic/mips_core_top.sv
// five-stage mips32 integer core
// stage and register file instances, sram and debug ports
module mips_core_top import isa_pkg::*, core_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    output logic [xlen-1:0]       inst_sram_addr,
    input  logic [xlen-1:0]       inst_sram_rdata,
    output logic [3:0]            data_sram_wen,
    output logic [xlen-1:0]       data_sram_addr,
    output logic [xlen-1:0]       data_sram_wdata,
    input  logic [xlen-1:0]       data_sram_rdata,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    // fetch and decode handshake
    logic                  allowin;
    logic                  branch_taken;
    logic [xlen-1:0]       branch_target;
    logic                  fd_valid;
    logic [xlen-1:0]       fd_pc;

    // register file read side
    logic [reg_addr_w-1:0] rf_raddr1;
    logic [reg_addr_w-1:0] rf_raddr2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;

    // decode to execute
    logic                  de_valid;
    logic [xlen-1:0]       de_pc;
    logic [xlen-1:0]       de_a;
    logic [xlen-1:0]       de_b;
    logic [xlen-1:0]       de_store_data;
    logic [alu_op_w-1:0]   de_alu_op;
    logic                  de_mem_read;
    logic                  de_mem_write;
    logic                  de_reg_write;
    logic [reg_addr_w-1:0] de_dest;

    // execute forwarding and execute to memory
    logic [xlen-1:0]       ex_result;
    logic [reg_addr_w-1:0] ex_dest;
    logic                  ex_reg_write;
    logic                  ex_mem_read;
    logic                  em_valid;
    logic [xlen-1:0]       em_pc;
    logic [xlen-1:0]       em_result;
    logic                  em_mem_read;
    logic                  em_reg_write;
    logic [reg_addr_w-1:0] em_dest;

    // memory and writeback results
    logic [xlen-1:0]       mem_result;
    logic                  wb_valid;
    logic                  wb_reg_write;
    logic [reg_addr_w-1:0] wb_dest;
    logic [xlen-1:0]       wb_data;

    fetch_stage fetch_i (
        .clk(clk), .resetn(resetn), .allowin(allowin),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .inst_sram_addr(inst_sram_addr), .fd_valid(fd_valid), .fd_pc(fd_pc)
    );

    decode_stage decode_i (
        .clk(clk), .resetn(resetn), .fd_valid(fd_valid), .fd_pc(fd_pc),
        .inst_sram_rdata(inst_sram_rdata),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_result(ex_result), .ex_dest(ex_dest),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .mem_valid(em_valid), .mem_result(mem_result), .mem_dest(em_dest),
        .mem_reg_write(em_reg_write),
        .wb_valid(wb_valid), .wb_data(wb_data), .wb_dest(wb_dest),
        .wb_reg_write(wb_reg_write),
        .allowin(allowin), .branch_taken(branch_taken), .branch_target(branch_target),
        .de_valid(de_valid), .de_pc(de_pc), .de_a(de_a), .de_b(de_b),
        .de_store_data(de_store_data), .de_alu_op(de_alu_op),
        .de_mem_read(de_mem_read), .de_mem_write(de_mem_write),
        .de_reg_write(de_reg_write), .de_dest(de_dest)
    );

    // write port follows the qualified debug enable
    reg_file rf_i (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .wen(debug_wb_rf_wen[0]), .waddr(wb_dest), .wdata(wb_data)
    );

    execute_stage execute_i (
        .clk(clk), .resetn(resetn),
        .de_valid(de_valid), .de_pc(de_pc), .de_a(de_a), .de_b(de_b),
        .de_store_data(de_store_data), .de_alu_op(de_alu_op),
        .de_mem_read(de_mem_read), .de_mem_write(de_mem_write),
        .de_reg_write(de_reg_write), .de_dest(de_dest),
        .data_sram_wen(data_sram_wen), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata),
        .ex_result(ex_result), .ex_dest(ex_dest),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .em_valid(em_valid), .em_pc(em_pc), .em_result(em_result),
        .em_mem_read(em_mem_read), .em_reg_write(em_reg_write), .em_dest(em_dest)
    );

    mem_wb_stage mem_wb_i (
        .clk(clk), .resetn(resetn),
        .em_valid(em_valid), .em_pc(em_pc), .em_result(em_result),
        .em_mem_read(em_mem_read), .em_reg_write(em_reg_write), .em_dest(em_dest),
        .data_sram_rdata(data_sram_rdata), .mem_result(mem_result),
        .wb_valid(wb_valid), .wb_reg_write(wb_reg_write),
        .wb_dest(wb_dest), .wb_data(wb_data),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock and reset source
module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // period 20
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset low for four rising edges, released on an edge
    initial begin
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

//--- verif/core_asserts.sv
// concurrent checks on the core sram and debug ports
// bound into mips_core_top
module core_asserts import isa_pkg::*; (
    input logic            clk,
    input logic            resetn,
    input logic [xlen-1:0] inst_sram_addr,
    input logic [3:0]      data_sram_wen,
    input logic [3:0]      debug_wb_rf_wen
);

    // word stores only, strobe all or nothing
    wen_all_or_none: assert property (
        @(posedge clk) disable iff (!resetn)
        data_sram_wen == 4'h0 || data_sram_wen == 4'hf
    ) else $error("data_sram_wen is %h, not 0 or f", data_sram_wen);

    // fetch stays on word boundaries
    fetch_aligned: assert property (
        @(posedge clk) disable iff (!resetn)
        inst_sram_addr[1:0] == 2'b00
    ) else $error("inst_sram_addr %h is not word aligned", inst_sram_addr);

    // nothing retires straight out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $rose(resetn) |-> debug_wb_rf_wen == 4'h0
    ) else $error("debug_wb_rf_wen is %h in the first cycle after reset", debug_wb_rf_wen);

endmodule

bind mips_core_top core_asserts core_asserts_i (
    .clk(clk),
    .resetn(resetn),
    .inst_sram_addr(inst_sram_addr),
    .data_sram_wen(data_sram_wen),
    .debug_wb_rf_wen(debug_wb_rf_wen)
);

//--- verif/tb_top.sv
// instruction rom and data ram models, program and retirement tables
// writeback and store checks, timeout and summary
module tb_top import isa_pkg::*; ();

    logic        clk;
    logic        resetn;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] rom [32];
    logic [31:0] ram [256];
    // expected retirements in program order
    logic [31:0] exp_pc  [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];
    // expected stores in program order
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    int          matched;
    int          stored;
    int          errors;
    int          cycles;
    int          limit;

    tb_clock_gen clk_gen_i (.clk(clk), .resetn(resetn));

    mips_core_top dut_i (
        .clk(clk), .resetn(resetn),
        .inst_sram_addr(inst_sram_addr), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_wen(data_sram_wen), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    // ------------------------------------------------------------------------
    // small assembler
    // ------------------------------------------------------------------------
    function automatic logic [31:0] pc_of(input int idx);
        return reset_pc + 32'(idx * 4);
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {op_special, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input int idx);
        logic [31:0] target;
        target = pc_of(idx);
        return {op_j, target[27:2]};
    endfunction

    task automatic add_retire(input int idx, input logic [4:0] rd, input logic [31:0] val);
        exp_pc.push_back(pc_of(idx));
        exp_reg.push_back(rd);
        exp_val.push_back(val);
    endtask

    task automatic add_store(input logic [31:0] addr, input logic [31:0] data);
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(data);
    endtask

    // ------------------------------------------------------------------------
    // program and expected retirements
    // ------------------------------------------------------------------------
    // skipped slots hold 0xbad writes
    task automatic load_program();
        // dependent alu chain exercising forwarding from every stage
        rom[0] = i_word(op_addiu, 1, 0, 16'h0005);
        add_retire(0, 1, 32'h5);
        rom[1] = i_word(op_addiu, 2, 1, 16'h0003);
        add_retire(1, 2, 32'h8);
        rom[2] = r_word(funct_addu, 3, 1, 2);
        add_retire(2, 3, 32'hd);
        rom[3] = r_word(funct_subu, 4, 3, 1);
        add_retire(3, 4, 32'h8);
        rom[4] = r_word(funct_and, 5, 4, 3);
        add_retire(4, 5, 32'h8);
        rom[5] = r_word(funct_or, 6, 5, 1);
        add_retire(5, 6, 32'hd);
        rom[6] = r_word(funct_slt, 7, 1, 6);
        add_retire(6, 7, 32'h1);
        rom[7] = i_word(op_lui, 8, 0, 16'h8000);
        add_retire(7, 8, 32'h8000_0000);
        // signed compare puts negative below positive
        rom[8] = r_word(funct_slt, 9, 8, 1);
        add_retire(8, 9, 32'h1);
        rom[9] = i_word(op_ori, 10, 8, 16'h1234);
        add_retire(9, 10, 32'h8000_1234);
        // store then load back with a load-use stall on the addu
        rom[10] = i_word(op_addiu, 11, 0, 16'h0100);
        add_retire(10, 11, 32'h100);
        rom[11] = i_word(op_sw, 10, 11, 16'h0000);
        add_store(32'h100, 32'h8000_1234);
        rom[12] = i_word(op_lw, 12, 11, 16'h0000);
        add_retire(12, 12, 32'h8000_1234);
        rom[13] = r_word(funct_addu, 13, 12, 1);
        add_retire(13, 13, 32'h8000_1239);
        // taken beq on a fresh result with target word 18
        rom[14] = i_word(op_beq, 13, 13, 16'd3);
        rom[15] = i_word(op_addiu, 14, 0, 16'h0007);
        add_retire(15, 14, 32'h7);
        rom[16] = i_word(op_addiu, 15, 0, 16'h0bad);
        rom[17] = i_word(op_addiu, 15, 0, 16'h0bad);
        // bne with equal operands falls through
        rom[18] = i_word(op_bne, 5, 4, 16'd2);
        rom[19] = i_word(op_addiu, 16, 0, 16'h0010);
        add_retire(19, 16, 32'h10);
        rom[20] = i_word(op_addiu, 17, 0, 16'h0011);
        add_retire(20, 17, 32'h11);
        // r0 write is dropped and r0 reads as zero
        rom[21] = i_word(op_addiu, 0, 0, 16'h0055);
        rom[22] = r_word(funct_addu, 18, 0, 1);
        add_retire(22, 18, 32'h5);
        rom[23] = j_word(26);
        rom[24] = i_word(op_addiu, 19, 0, 16'h0013);
        add_retire(24, 19, 32'h13);
        rom[25] = i_word(op_addiu, 19, 0, 16'h0bad);
        rom[26] = i_word(op_addiu, 20, 17, 16'hffff);
        add_retire(26, 20, 32'h10);
        // branch right behind its producer
        rom[27] = i_word(op_beq, 16, 20, 16'd2);
        rom[28] = i_word(op_addiu, 21, 0, 16'h0015);
        add_retire(28, 21, 32'h15);
        rom[29] = i_word(op_addiu, 21, 0, 16'h0bad);
        rom[30] = i_word(op_addiu, 22, 21, 16'h0001);
        add_retire(30, 22, 32'h16);
    endtask

    // ------------------------------------------------------------------------
    // memory models with one cycle read latency
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] off;
        off = (addr - reset_pc) >> 2;
        // nops past the program
        if (off < 32) begin
            return rom[off];
        end
        return 32'h0;
    endfunction

    always @(posedge clk) begin
        inst_sram_rdata <= rom_word(inst_sram_addr);
    end

    always @(posedge clk) begin
        if (data_sram_wen == 4'hf) begin
            ram[data_sram_addr[9:2]] <= data_sram_wdata;
        end
        data_sram_rdata <= ram[data_sram_addr[9:2]];
    end

    // one debug writeback against the next table entry
    task automatic check_write();
        if (matched >= exp_pc.size()) begin
            errors++;
            $display("unexpected writeback at pc %h beyond the last expected entry",
                     debug_wb_pc);
        end else begin
            if (debug_wb_rf_wen !== 4'hf) begin
                errors++;
                $display("FAIL debug_wb_rf_wen expected f got %h", debug_wb_rf_wen);
            end
            if (debug_wb_pc !== exp_pc[matched]) begin
                errors++;
                $display("FAIL debug_wb_pc expected %h got %h", exp_pc[matched], debug_wb_pc);
            end
            if (debug_wb_rf_wnum !== exp_reg[matched]) begin
                errors++;
                $display("FAIL debug_wb_rf_wnum expected %h got %h",
                         exp_reg[matched], debug_wb_rf_wnum);
            end
            if (debug_wb_rf_wdata !== exp_val[matched]) begin
                errors++;
                $display("FAIL debug_wb_rf_wdata expected %h got %h",
                         exp_val[matched], debug_wb_rf_wdata);
            end
            matched++;
        end
    endtask

    // one data sram write against the next store entry
    task automatic check_store();
        if (stored >= exp_st_addr.size()) begin
            errors++;
            $display("unexpected store to address %h beyond the last expected store",
                     data_sram_addr);
        end else begin
            if (data_sram_wen !== 4'hf) begin
                errors++;
                $display("FAIL data_sram_wen expected f got %h", data_sram_wen);
            end
            if (data_sram_addr !== exp_st_addr[stored]) begin
                errors++;
                $display("FAIL data_sram_addr expected %h got %h",
                         exp_st_addr[stored], data_sram_addr);
            end
            if (data_sram_wdata !== exp_st_data[stored]) begin
                errors++;
                $display("FAIL data_sram_wdata expected %h got %h",
                         exp_st_data[stored], data_sram_wdata);
            end
            stored++;
        end
    endtask

    initial begin
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        matched = 0;
        stored  = 0;
        errors  = 0;
        cycles  = 0;
        for (int i = 0; i < 256; i++) begin
            ram[i] = 32'h0;
        end
        for (int i = 0; i < 32; i++) begin
            rom[i] = 32'h0;
        end
        load_program();
        limit = 4 * exp_pc.size() + 40;

        // sample once per cycle on the falling edge
        while (matched < exp_pc.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (!resetn) begin
                if (inst_sram_addr !== reset_pc) begin
                    errors++;
                    $display("FAIL inst_sram_addr expected %h got %h",
                             reset_pc, inst_sram_addr);
                end
            end else begin
                if (debug_wb_rf_wen !== 4'h0) begin
                    check_write();
                end
                if (data_sram_wen !== 4'h0) begin
                    check_store();
                end
            end
        end
        if (matched < exp_pc.size()) begin
            errors++;
            $display("timeout after %0d cycles, only %0d of %0d writebacks seen",
                     cycles, matched, exp_pc.size());
        end

        // trailing nops must stay quiet
        repeat (8) begin
            @(negedge clk);
            if (debug_wb_rf_wen !== 4'h0) begin
                check_write();
            end
            if (data_sram_wen !== 4'h0) begin
                check_store();
            end
        end
        if (stored != exp_st_addr.size()) begin
            errors++;
            $display("only %0d of %0d expected stores reached the data sram",
                     stored, exp_st_addr.size());
        end

        $display("%0d of %0d writebacks and %0d of %0d stores matched, %0d errors",
                 matched, exp_pc.size(), stored, exp_st_addr.size(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
logic/isa_pkg.sv
logic/core_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/mips_core_top.sv
verif/tb_clock_gen.sv
verif/core_asserts.sv
verif/tb_top.sv
